//--- project.f
common/rename_pkg.sv
rename/map_table.sv
rename/free_list.sv
rename/reorder_buffer.sv
rename/rename_core.sv
tb/rename_asserts.sv
tb/rename_tb.sv

//--- run.sh
#!/bin/sh
# build the rename core testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module rename_tb \
  -Mdir obj_dir -f project.f || exit 1
./obj_dir/Vrename_tb +verilator+error+limit+1000 | tee /dev/stderr \
  | grep "^ALL CHECKS PASSED$" > /dev/null \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }

//--- tb/rename_tb.sv
// testbench for the rename core with random dispatch and completion from a fixed seed
// a model of map, free list and in-flight queue predicts every output

`timescale 1ns/1ps

module rename_tb;
  import rename_pkg::*;

  localparam int  rob_depth     = 16;
  localparam real clock_period  = 40.0;
  localparam int  reset_cycles  = 8;
  localparam int  random_cycles = 2000;
  // generous bound for reset_state, drain and rob_fill together
  localparam int  phase_cycles  = 300;
  localparam int  total_cycles  = reset_cycles + random_cycles + phase_cycles;

  // one in-flight instruction as the model sees it
  typedef struct packed {
    arch_reg_t dest;
    phys_reg_t t_new;
    phys_reg_t t_old;
    logic      done;
  } flight_t;

  logic           clock = 1'b0;
  logic           reset;
  logic           dispatch_valid;
  dispatch_req_t  dispatch;
  logic           dispatch_ready;
  rename_result_t rename;
  logic           cdb_valid;
  phys_reg_t      cdb_tag;
  logic           retire_valid;
  retire_t        retire;

  // inputs for the coming cycle, picked at the negedge
  logic           nxt_valid;
  dispatch_req_t  nxt_req;
  logic           nxt_cdb;
  phys_reg_t      nxt_tag;

  // reference model
  phys_reg_t      model_tag [num_arch_reg];
  logic           model_ready [num_arch_reg];
  phys_reg_t      free_q [$];
  flight_t        flight_q [$];
  logic           retired_now;
  // retires seen on the core's port
  int             retire_count;

  int             checks;
  int             errors;
  int             tests_run;
  int             test_checks;
  int             test_errors;
  string          test_name;

  always #(clock_period / 2.0) clock = ~clock;

  rename_core #(.rob_depth(rob_depth)) dut (
    .clock          (clock),
    .reset          (reset),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .dispatch_ready (dispatch_ready),
    .rename         (rename),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .retire_valid   (retire_valid),
    .retire         (retire)
  );

  //////////////////////////////////////////////////
  // bookkeeping
  //////////////////////////////////////////////////

  task automatic report_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
    errors++;
    test_errors++;
    $display("Fail %s %s: expected %h, actual %h", test_name, what, expected, actual);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    checks += test_checks;
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  //////////////////////////////////////////////////
  // model
  //////////////////////////////////////////////////

  // identity map with tags 32 to 63 free in order and nothing in flight
  task automatic reset_model();
    for (int i = 0; i < num_arch_reg; i++) begin
      model_tag[i]   = phys_reg_t'(i);
      model_ready[i] = 1'b1;
    end
    free_q   = {};
    flight_q = {};
    for (int i = 0; i < num_free_reg; i++) begin
      free_q.push_back(phys_reg_t'(num_arch_reg + i));
    end
  endtask

  // compare everything the core shows in this cycle
  task automatic check_outputs();
    logic           exp_ready;
    logic           exp_retire;
    rename_result_t exp_rename;
    retire_t        exp_head;
    exp_ready = (flight_q.size() < rob_depth) && (free_q.size() > 0);
    test_checks++;
    if (dispatch_ready !== exp_ready) begin
      report_value("dispatch_ready", 32'(exp_ready), 32'(dispatch_ready));
    end
    if (dispatch_valid) begin
      exp_rename.t1       = model_tag[dispatch.src_a];
      exp_rename.t2       = model_tag[dispatch.src_b];
      // same-cycle broadcast counts as ready
      exp_rename.t1_ready = model_ready[dispatch.src_a] |
                            (cdb_valid && (cdb_tag == model_tag[dispatch.src_a]));
      exp_rename.t2_ready = model_ready[dispatch.src_b] |
                            (cdb_valid && (cdb_tag == model_tag[dispatch.src_b]));
      exp_rename.t_new    = free_q[0];
      exp_rename.t_old    = model_tag[dispatch.dest];
      test_checks++;
      if (rename !== exp_rename) begin
        report_value("rename", 32'(exp_rename), 32'(rename));
      end
    end
    // only a completed head may leave
    exp_retire = (flight_q.size() > 0) && flight_q[0].done;
    test_checks++;
    if (retire_valid !== exp_retire) begin
      report_value("retire_valid", 32'(exp_retire), 32'(retire_valid));
    end
    if (retire_valid === 1'b1) begin
      retire_count++;
    end
    if (exp_retire) begin
      exp_head = '{dest: flight_q[0].dest, t_new: flight_q[0].t_new, t_old: flight_q[0].t_old};
      test_checks++;
      if (retire !== exp_head) begin
        report_value("retire", 32'(exp_head), 32'(retire));
      end
    end
  endtask

  // what the coming rising edge does to the tables
  task automatic advance_model();
    flight_t   entry;
    flight_t   leaving;
    phys_reg_t issued;
    retired_now = (flight_q.size() > 0) && flight_q[0].done;
    // broadcast marks the entry and any row still mapped to the tag
    if (cdb_valid) begin
      foreach (flight_q[i]) begin
        if (flight_q[i].t_new == cdb_tag) begin
          entry      = flight_q[i];
          entry.done = 1'b1;
          flight_q[i] = entry;
        end
      end
      for (int r = 0; r < num_arch_reg; r++) begin
        if (model_tag[r] == cdb_tag) begin
          model_ready[r] = 1'b1;
        end
      end
    end
    if (retired_now) begin
      leaving = flight_q.pop_front();
    end
    // new mapping written not ready and wins over the broadcast
    if (dispatch_valid) begin
      issued = free_q.pop_front();
      entry  = '{dest: dispatch.dest, t_new: issued, t_old: model_tag[dispatch.dest],
                 done: 1'b0};
      flight_q.push_back(entry);
      model_tag[dispatch.dest]   = issued;
      model_ready[dispatch.dest] = 1'b0;
    end
    // old tag recycled at the back
    if (retired_now) begin
      free_q.push_back(leaving.t_old);
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  // dispatch only while the model has room, complete only open tags
  task automatic choose_inputs(input int dispatch_pct, input int complete_pct);
    int open_idx [$];
    foreach (flight_q[i]) begin
      if (!flight_q[i].done) begin
        open_idx.push_back(i);
      end
    end
    nxt_valid = (flight_q.size() < rob_depth) && (free_q.size() > 0) &&
                (($urandom % 100) < dispatch_pct);
    nxt_req   = dispatch_req_t'($urandom);
    nxt_cdb   = 1'b0;
    nxt_tag   = phys_reg_t'($urandom);
    if ((open_idx.size() > 0) && (($urandom % 100) < complete_pct)) begin
      nxt_cdb = 1'b1;
      nxt_tag = flight_q[open_idx[$urandom % open_idx.size()]].t_new;
    end
  endtask

  // drive at the rising edge, check and update at the falling edge
  task automatic step();
    @(posedge clock);
    dispatch_valid <= nxt_valid;
    dispatch       <= nxt_req;
    cdb_valid      <= nxt_cdb;
    cdb_tag        <= nxt_tag;
    @(negedge clock);
    check_outputs();
    advance_model();
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h5bee));
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch       = '0;
    cdb_valid      = 1'b0;
    cdb_tag        = '0;
    nxt_valid      = 1'b0;
    nxt_req        = '0;
    nxt_cdb        = 1'b0;
    nxt_tag        = '0;
    checks         = 0;
    errors         = 0;
    tests_run      = 0;
    retire_count   = 0;
    reset_model();
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;

    // first tags come out of the initial pool in order
    start_test("reset_state");
    @(negedge clock);
    test_checks++;
    if ((dispatch_ready !== 1'b1) || (retire_valid !== 1'b0)) begin
      report_value("ready and retire after reset", 32'b10,
                   32'({dispatch_ready, retire_valid}));
    end
    repeat (12) begin
      choose_inputs(100, 0);
      step();
    end
    finish_test();

    // mixed traffic with a window without completions every 500 cycles
    start_test("random_mix");
    for (int cyc = 0; cyc < random_cycles; cyc++) begin
      choose_inputs(60, ((cyc % 500) >= 400) ? 0 : 40);
      step();
    end
    test_checks++;
    if (retire_count == 0) begin
      errors++;
      test_errors++;
      $display("no instruction retired during %s", test_name);
    end
    finish_test();

    start_test("drain");
    while (flight_q.size() > 0) begin
      choose_inputs(0, 100);
      step();
    end
    finish_test();

    // fill the buffer with completion off
    start_test("rob_fill");
    dispatch_ready_wait : while (1'b1) begin
      choose_inputs(100, 0);
      step();
      if (!dispatch_ready) begin
        break;
      end
    end
    test_checks++;
    if (flight_q.size() != rob_depth) begin
      report_value("instructions in flight at stall", 32'(rob_depth), 32'(flight_q.size()));
    end
    // complete the oldest only
    choose_inputs(0, 0);
    nxt_cdb = 1'b1;
    nxt_tag = flight_q[0].t_new;
    step();
    choose_inputs(0, 0);
    step();
    test_checks++;
    if ((retire_valid !== 1'b1) || (dispatch_ready !== 1'b0)) begin
      report_value("retire and ready after head completion", 32'b10,
                   32'({retire_valid, dispatch_ready}));
    end
    choose_inputs(0, 0);
    step();
    test_checks++;
    if (dispatch_ready !== 1'b1) begin
      report_value("dispatch_ready after first retire", 32'h1, 32'(dispatch_ready));
    end
    finish_test();

    if (dut.u_rename_asserts.failures != 0) begin
      errors++;
      $display("assertion monitor caught %0d violations", dut.u_rename_asserts.failures);
    end
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // hang guard at 2.5 times the longest expected run
  initial begin
    #(clock_period * 2.5 * total_cycles);
    $display("watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- tb/rename_asserts.sv
// protocol assertions for the rename core, bound into rename_core
// violations show up as $error and in the failure count

`timescale 1ns/1ps

module rename_asserts (
  input logic                       clock,
  input logic                       reset,
  input logic                       dispatch_valid,
  input logic                       dispatch_ready,
  input rename_pkg::rename_result_t rename,
  input logic                       retire_valid
);

  int unsigned failures = 0;

  // environment never strobes into a stall
  no_dispatch_when_stalled : assert property (@(posedge clock) disable iff (reset)
    dispatch_valid |-> dispatch_ready)
    else begin
      failures++;
      $error("dispatch strobe while dispatch_ready is low");
    end

  // fresh tag always differs from the one it replaces
  new_tag_differs : assert property (@(posedge clock) disable iff (reset)
    (dispatch_valid && dispatch_ready) |-> (rename.t_new != rename.t_old))
    else begin
      failures++;
      $error("dispatch got t_new equal to t_old");
    end

  // once reset has taken hold, nothing retires
  quiet_in_reset : assert property (@(posedge clock)
    (reset && $past(reset)) |-> !retire_valid)
    else begin
      failures++;
      $error("retire_valid high during reset");
    end

endmodule

bind rename_core rename_asserts u_rename_asserts (
  .clock          (clock),
  .reset          (reset),
  .dispatch_valid (dispatch_valid),
  .dispatch_ready (dispatch_ready),
  .rename         (rename),
  .retire_valid   (retire_valid)
);

//--- rename/rename_core.sv
// top of the rename core, map table plus free list plus reorder buffer
// dispatch handshake, completion broadcast in, one retire per cycle out

`timescale 1ns/1ps

module rename_core #(
  parameter int rob_depth = 16
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatch_valid,
  input  rename_pkg::dispatch_req_t  dispatch,
  output logic                       dispatch_ready,
  output rename_pkg::rename_result_t rename,
  input  logic                       cdb_valid,
  input  rename_pkg::phys_reg_t      cdb_tag,
  output logic                       retire_valid,
  output rename_pkg::retire_t        retire
);
  import rename_pkg::*;

  logic      rob_full;
  logic      fl_empty;
  logic      do_dispatch;
  phys_reg_t fl_head_tag;
  phys_reg_t mt_t1;
  phys_reg_t mt_t2;
  phys_reg_t mt_t_old;
  logic      mt_t1_ready;
  logic      mt_t2_ready;

  //////////////////////////////////////////////////
  // dispatch stall
  //////////////////////////////////////////////////

  // both terms come from registered counts
  assign dispatch_ready = ~rob_full & ~fl_empty;
  assign do_dispatch    = dispatch_valid & dispatch_ready;

  assign rename = '{t1: mt_t1, t1_ready: mt_t1_ready, t2: mt_t2, t2_ready: mt_t2_ready,
                    t_new: fl_head_tag, t_old: mt_t_old};

  map_table u_map_table (
    .clock     (clock),
    .reset     (reset),
    .rename_en (do_dispatch),
    .dispatch  (dispatch),
    .t_new     (fl_head_tag),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .t1        (mt_t1),
    .t1_ready  (mt_t1_ready),
    .t2        (mt_t2),
    .t2_ready  (mt_t2_ready),
    .t_old     (mt_t_old)
  );

  // retiring old tag goes straight back
  free_list u_free_list (
    .clock    (clock),
    .reset    (reset),
    .pop      (do_dispatch),
    .push     (retire_valid),
    .push_tag (retire.t_old),
    .head_tag (fl_head_tag),
    .empty    (fl_empty)
  );

  reorder_buffer #(.rob_depth(rob_depth)) u_reorder_buffer (
    .clock        (clock),
    .reset        (reset),
    .alloc        (do_dispatch),
    .alloc_dest   (dispatch.dest),
    .alloc_t_new  (fl_head_tag),
    .alloc_t_old  (mt_t_old),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .full         (rob_full),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

//--- rename/reorder_buffer.sv
// in-order queue of renamed instructions with completion bits
// completion searches every entry by t_new, the head leaves once complete

`timescale 1ns/1ps

module reorder_buffer #(
  parameter int rob_depth = 16
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc,
  input  rename_pkg::arch_reg_t alloc_dest,
  input  rename_pkg::phys_reg_t alloc_t_new,
  input  rename_pkg::phys_reg_t alloc_t_old,
  input  logic                  cdb_valid,
  input  rename_pkg::phys_reg_t cdb_tag,
  output logic                  full,
  output logic                  retire_valid,
  output rename_pkg::retire_t   retire
);
  import rename_pkg::*;

  localparam int ptr_w = $clog2(rob_depth);
  localparam int cnt_w = $clog2(rob_depth + 1);

  // payload per entry, same layout as the retire port
  retire_t          entries [rob_depth];
  logic             complete [rob_depth];
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(rob_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // status and retire port
  //////////////////////////////////////////////////

  assign full = (count == cnt_w'(rob_depth));
  // empty queue never retires, stale complete bits ignored
  assign retire_valid = (count != '0) && complete[head];
  assign retire       = entries[head];

  //////////////////////////////////////////////////
  // entry payload
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (alloc) begin
      entries[tail].dest  <= alloc_dest;
      entries[tail].t_new <= alloc_t_new;
      entries[tail].t_old <= alloc_t_old;
    end
  end

  //////////////////////////////////////////////////
  // completion, pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rob_depth; i++) begin
        complete[i] <= 1'b0;
      end
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      // tag search over all entries
      for (int i = 0; i < rob_depth; i++) begin
        if (cdb_valid && (entries[i].t_new == cdb_tag)) begin
          complete[i] <= 1'b1;
        end
      end
      // fresh entry starts incomplete, overrides a stale match
      if (alloc) begin
        complete[tail] <= 1'b0;
        tail           <= next_ptr(tail);
      end
      if (retire_valid) begin
        head <= next_ptr(head);
      end
      case ({alloc, retire_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rename/free_list.sv
// circular queue of unallocated physical tags
// head tag is offered every cycle, pop on dispatch and push on retire

`timescale 1ns/1ps

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pop,
  input  logic                  push,
  input  rename_pkg::phys_reg_t push_tag,
  output rename_pkg::phys_reg_t head_tag,
  output logic                  empty
);
  import rename_pkg::*;

  localparam int ptr_w = $clog2(num_free_reg);
  localparam int cnt_w = $clog2(num_free_reg + 1);

  phys_reg_t          slots [num_free_reg];
  logic [ptr_w-1:0]   head;
  logic [ptr_w-1:0]   tail;
  logic [cnt_w-1:0]   count;

  // wrap at the end of the slot array
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(num_free_reg - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_tag = slots[head];
  assign empty    = (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the identity map, ascending
      for (int i = 0; i < num_free_reg; i++) begin
        slots[i] <= phys_reg_t'(num_arch_reg + i);
      end
      head  <= '0;
      tail  <= '0;
      count <= cnt_w'(num_free_reg);
    end else begin
      if (pop) begin
        head <= next_ptr(head);
      end
      // recycled old tag goes in at the back
      if (push) begin
        slots[tail] <= push_tag;
        tail        <= next_ptr(tail);
      end
      // pop and push together leave count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rename/map_table.sv
// architectural-to-physical map with one ready bit per register
// sources and old dest are looked up combinationally, writes land at the edge

`timescale 1ns/1ps

module map_table (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      rename_en,
  input  rename_pkg::dispatch_req_t dispatch,
  input  rename_pkg::phys_reg_t     t_new,
  input  logic                      cdb_valid,
  input  rename_pkg::phys_reg_t     cdb_tag,
  output rename_pkg::phys_reg_t     t1,
  output logic                      t1_ready,
  output rename_pkg::phys_reg_t     t2,
  output logic                      t2_ready,
  output rename_pkg::phys_reg_t     t_old
);
  import rename_pkg::*;

  // one row per architectural register
  typedef struct packed {
    phys_reg_t tag;
    logic      ready;
  } map_row_t;

  map_row_t rows [num_arch_reg];
  map_row_t row_a;
  map_row_t row_b;

  //////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////

  assign row_a = rows[dispatch.src_a];
  assign row_b = rows[dispatch.src_b];

  assign t1 = row_a.tag;
  assign t2 = row_b.tag;
  // completion in this very cycle counts as ready
  assign t1_ready = row_a.ready | (cdb_valid && (cdb_tag == row_a.tag));
  assign t2_ready = row_b.ready | (cdb_valid && (cdb_tag == row_b.tag));
  // mapping that dest is about to lose
  assign t_old = rows[dispatch.dest].tag;

  //////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, everything ready
      for (int i = 0; i < num_arch_reg; i++) begin
        rows[i].tag   <= phys_reg_t'(i);
        rows[i].ready <= 1'b1;
      end
    end else begin
      // broadcast match, any row still pointing at the tag
      for (int i = 0; i < num_arch_reg; i++) begin
        if (cdb_valid && (rows[i].tag == cdb_tag)) begin
          rows[i].ready <= 1'b1;
        end
      end
      // new mapping wins over a completion of the old tag
      if (rename_en) begin
        rows[dispatch.dest].tag   <= t_new;
        rows[dispatch.dest].ready <= 1'b0;
      end
    end
  end

endmodule

//--- common/rename_pkg.sv
// shared widths, tag types and port structs for the register-renaming core
// imported by every block under rename/ and by the testbench

package rename_pkg;

  //////////////////////////////////////////////////
  // register file sizes
  //////////////////////////////////////////////////

  // architectural registers seen by software
  localparam int num_arch_reg = 32;
  // physical registers behind the map table
  localparam int num_phys_reg = 64;
  // tags not mapped after reset, all of them start out free
  localparam int num_free_reg = num_phys_reg - num_arch_reg;

  //////////////////////////////////////////////////
  // index and tag types
  //////////////////////////////////////////////////

  typedef logic [$clog2(num_arch_reg)-1:0] arch_reg_t;
  typedef logic [$clog2(num_phys_reg)-1:0] phys_reg_t;

  // one dispatched instruction, register fields only
  typedef struct packed {
    arch_reg_t dest;
    arch_reg_t src_a;
    arch_reg_t src_b;
  } dispatch_req_t;

  // rename answer, valid in the dispatch cycle
  typedef struct packed {
    phys_reg_t t1;
    logic      t1_ready;
    phys_reg_t t2;
    logic      t2_ready;
    // fresh tag from the free list
    phys_reg_t t_new;
    // previous mapping of dest, freed at retire
    phys_reg_t t_old;
  } rename_result_t;

  // head of the reorder buffer as it leaves
  typedef struct packed {
    arch_reg_t dest;
    phys_reg_t t_new;
    phys_reg_t t_old;
  } retire_t;

endpackage
